// ==== Makefile ====
TOP := tb_cascaded_reset_dist

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== design/axi_lite_slave.sv ====
// AXI4-Lite slave engine, turns bus transactions into single-cycle register bus accesses
`timescale 1ns/1ps

module axi_lite_slave (
    input  logic        s_axi_aclk,
    input  logic        s_axi_aresetn,
    // Write address channel
    input  logic [31:0] s_axi_awaddr,
    input  logic [2:0]  s_axi_awprot,
    input  logic        s_axi_awvalid,
    output logic        s_axi_awready,
    // Write data channel
    input  logic [31:0] s_axi_wdata,
    input  logic [3:0]  s_axi_wstrb,
    input  logic        s_axi_wvalid,
    output logic        s_axi_wready,
    // Write response channel
    output logic [1:0]  s_axi_bresp,
    output logic        s_axi_bvalid,
    input  logic        s_axi_bready,
    // Read address channel
    input  logic [31:0] s_axi_araddr,
    input  logic [2:0]  s_axi_arprot,
    input  logic        s_axi_arvalid,
    output logic        s_axi_arready,
    // Read data channel
    output logic [31:0] s_axi_rdata,
    output logic [1:0]  s_axi_rresp,
    output logic        s_axi_rvalid,
    input  logic        s_axi_rready,
    // Register access side
    reg_bus_if.master   bus
);
    import rst_dist_pkg::*;

    // Write path state
    logic        aw_en;
    logic        awready_q;
    logic        bvalid_q;
    logic [1:0]  bresp_q;
    logic        wr_start;

    // Read path state
    logic        ar_en;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic [1:0]  rresp_q;
    logic        rd_accept;

    // Address and data must both be present, and no response may be pending
    assign wr_start = s_axi_awvalid && s_axi_wvalid && !awready_q && aw_en && !bvalid_q;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            awready_q <= 1'b0;
            aw_en     <= 1'b1;
        end else begin
            // One-cycle ready pulse for both channels
            awready_q <= wr_start;
            if (wr_start) begin
                aw_en <= 1'b0;
            end else if (bvalid_q && s_axi_bready) begin
                aw_en <= 1'b1;
            end
        end
    end

    // Response raised at the edge that commits the write
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            bvalid_q <= 1'b0;
        end else if (awready_q) begin
            bvalid_q <= 1'b1;
        end else if (bvalid_q && s_axi_bready) begin
            bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (awready_q) begin
            bresp_q <= bus.wr_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // Read side enabled one cycle out of reset
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            ar_en <= 1'b0;
        end else begin
            ar_en <= 1'b1;
        end
    end

    assign s_axi_arready = ar_en && !rvalid_q;
    assign rd_accept     = s_axi_arvalid && s_axi_arready;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rvalid_q <= 1'b0;
        end else if (rd_accept) begin
            rvalid_q <= 1'b1;
        end else if (s_axi_rready) begin
            rvalid_q <= 1'b0;
        end
    end

    // Data and response only load on acceptance, so they hold under back-pressure
    always_ff @(posedge s_axi_aclk) begin
        if (rd_accept) begin
            rdata_q <= bus.rd_data;
            rresp_q <= bus.rd_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // Register bus requests
    assign bus.wr_en   = awready_q;
    assign bus.wr_addr = s_axi_awaddr[ADDR_BITS-1:0];
    assign bus.wr_data = s_axi_wdata;
    assign bus.wr_strb = s_axi_wstrb;
    assign bus.rd_en   = rd_accept;
    assign bus.rd_addr = s_axi_araddr[ADDR_BITS-1:0];

    // AXI outputs
    assign s_axi_awready = awready_q;
    assign s_axi_wready  = awready_q;
    assign s_axi_bvalid  = bvalid_q;
    assign s_axi_bresp   = bresp_q;
    assign s_axi_rvalid  = rvalid_q;
    assign s_axi_rdata   = rdata_q;
    assign s_axi_rresp   = rresp_q;

endmodule

// ==== design/cascaded_reset_dist.sv ====
// Top level of the AXI4-Lite controlled reset distributor with plain AXI ports
`timescale 1ns/1ps

module cascaded_reset_dist (
    input  logic                              s_axi_aclk,
    input  logic                              s_axi_aresetn,
    // Write address channel
    input  logic [31:0]                       s_axi_awaddr,
    input  logic [2:0]                        s_axi_awprot,
    input  logic                              s_axi_awvalid,
    output logic                              s_axi_awready,
    // Write data channel
    input  logic [31:0]                       s_axi_wdata,
    input  logic [3:0]                        s_axi_wstrb,
    input  logic                              s_axi_wvalid,
    output logic                              s_axi_wready,
    // Write response channel
    output logic [1:0]                        s_axi_bresp,
    output logic                              s_axi_bvalid,
    input  logic                              s_axi_bready,
    // Read address channel
    input  logic [31:0]                       s_axi_araddr,
    input  logic [2:0]                        s_axi_arprot,
    input  logic                              s_axi_arvalid,
    output logic                              s_axi_arready,
    // Read data channel
    output logic [31:0]                       s_axi_rdata,
    output logic [1:0]                        s_axi_rresp,
    output logic                              s_axi_rvalid,
    input  logic                              s_axi_rready,
    // Active-high reset outputs
    output logic [rst_dist_pkg::N_STAGES-1:0] rst_cascade
);
    logic rst_req;

    reg_bus_if bus_i ();

    axi_lite_slave u_axi_lite_slave (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awprot  (s_axi_awprot),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arprot  (s_axi_arprot),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .bus           (bus_i.master)
    );

    rst_ctrl_regs u_rst_ctrl_regs (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .bus           (bus_i.slave),
        .rst_req       (rst_req),
        .rst_cascade   (rst_cascade)
    );

    reset_cascade u_reset_cascade (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .rst_req       (rst_req),
        .rst_cascade   (rst_cascade)
    );

endmodule

// ==== design/reg_bus_if.sv ====
// Register access bus between the AXI4-Lite front end and the register block
`timescale 1ns/1ps

interface reg_bus_if;
    import rst_dist_pkg::*;

    // Write request, single-cycle pulse with address and data
    logic                 wr_en;
    logic [ADDR_BITS-1:0] wr_addr;
    logic [31:0]          wr_data;
    logic [3:0]           wr_strb;
    logic                 wr_err;

    // Read request, answered in the same cycle
    logic                 rd_en;
    logic [ADDR_BITS-1:0] rd_addr;
    logic [31:0]          rd_data;
    logic                 rd_err;

    modport master (
        output wr_en, wr_addr, wr_data, wr_strb, rd_en, rd_addr,
        input  wr_err, rd_data, rd_err
    );

    modport slave (
        input  wr_en, wr_addr, wr_data, wr_strb, rd_en, rd_addr,
        output wr_err, rd_data, rd_err
    );

endinterface

// ==== design/reset_cascade.sv ====
// Staged reset chain, releases the outputs one cycle apart from the most significant bit
`timescale 1ns/1ps

module reset_cascade (
    input  logic                              s_axi_aclk,
    input  logic                              s_axi_aresetn,
    input  logic                              rst_req,
    output logic [rst_dist_pkg::N_STAGES-1:0] rst_cascade
);
    import rst_dist_pkg::*;

    // Stage 0 is the first to release
    logic [N_STAGES-1:0] stage;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn || rst_req) begin
            stage <= '1;
        end else begin
            stage <= {stage[N_STAGES-2:0], 1'b0};
        end
    end

    // Output register, bit order reversed so the first stage drives the MSB
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rst_cascade <= '1;
        end else begin
            for (int i = 0; i < N_STAGES; i++) begin
                rst_cascade[N_STAGES-1-i] <= stage[i];
            end
        end
    end

endmodule

// ==== design/rst_ctrl_regs.sv ====
// Control and status registers of the reset distributor, decoded from the register bus
`timescale 1ns/1ps

module rst_ctrl_regs (
    input  logic                              s_axi_aclk,
    input  logic                              s_axi_aresetn,
    reg_bus_if.slave                          bus,
    output logic                              rst_req,
    input  logic [rst_dist_pkg::N_STAGES-1:0] rst_cascade
);
    import rst_dist_pkg::*;

    logic ctrl_hit;

    assign ctrl_hit = bus.wr_addr == ADDR_RST_CONTROL;

    // Reset request starts asserted so every output is held after power-up
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rst_req <= 1'b1;
        end else if (bus.wr_en && ctrl_hit && bus.wr_strb[0]) begin
            rst_req <= bus.wr_data[0];
        end
    end

    // Status is read-only, anything besides control is an error
    assign bus.wr_err = bus.wr_en && !ctrl_hit;

    always_comb begin
        bus.rd_data = '0;
        bus.rd_err  = 1'b0;
        if (bus.rd_en) begin
            case (bus.rd_addr)
                ADDR_RST_CONTROL: begin
                    bus.rd_data = {31'b0, rst_req};
                end
                ADDR_RST_STATUS: begin
                    bus.rd_data = {{(32-N_STAGES){1'b0}}, rst_cascade};
                end
                default: begin
                    // Unmapped offset reads zero
                    bus.rd_err = 1'b1;
                end
            endcase
        end
    end

endmodule

// ==== design/rst_dist_pkg.sv ====
// Shared constants for the reset distributor: register map, AXI response codes, stage count
package rst_dist_pkg;

    // Number of cascaded reset outputs
    localparam int N_STAGES = 4;

    // Low address bits seen by the register decode
    localparam int ADDR_BITS = 4;

    // Register map, byte offsets
    // Control: bit 0 is the reset request, read/write, set after reset
    localparam logic [ADDR_BITS-1:0] ADDR_RST_CONTROL = 4'h0;
    // Status: read-only view of the reset output vector
    localparam logic [ADDR_BITS-1:0] ADDR_RST_STATUS  = 4'h4;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== flist.f ====
design/rst_dist_pkg.sv
design/reg_bus_if.sv
design/axi_lite_slave.sv
design/rst_ctrl_regs.sv
design/reset_cascade.sv
design/cascaded_reset_dist.sv
tb/rst_dist_checker.sv
tb/tb_cascaded_reset_dist.sv

// ==== tb/rst_dist_checker.sv ====
// Assertion module bound into the reset distributor top, checks handshakes and release order
`timescale 1ns/1ps

module rst_dist_checker (
    input logic                              s_axi_aclk,
    input logic                              s_axi_aresetn,
    input logic                              s_axi_awready,
    input logic                              s_axi_arready,
    input logic [1:0]                        s_axi_bresp,
    input logic                              s_axi_bvalid,
    input logic                              s_axi_bready,
    input logic [31:0]                       s_axi_rdata,
    input logic [1:0]                        s_axi_rresp,
    input logic                              s_axi_rvalid,
    input logic                              s_axi_rready,
    input logic [rst_dist_pkg::N_STAGES-1:0] rst_cascade
);
    import rst_dist_pkg::*;

    // Adding one to a thermometer code clears every set bit
    logic [N_STAGES-1:0] cascade_inc;

    assign cascade_inc = rst_cascade + {{(N_STAGES-1){1'b0}}, 1'b1};

    bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
        else $error("Write response dropped or changed before bready");

    rdata_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=>
            s_axi_rvalid && $stable(s_axi_rdata) && $stable(s_axi_rresp))
        else $error("Read data or rvalid changed while rready was low");

    // A cleared output implies all higher outputs are cleared
    cascade_order: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        (rst_cascade & cascade_inc) == '0)
        else $error("rst_cascade released out of order");

    // Ready outputs settle low one edge after reset is sampled
    ready_in_reset: assert property (@(posedge s_axi_aclk)
        !s_axi_aresetn |=> !s_axi_awready && !s_axi_arready)
        else $error("awready or arready high during reset");

endmodule

bind cascaded_reset_dist rst_dist_checker u_rst_dist_checker (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .s_axi_awready (s_axi_awready),
    .s_axi_arready (s_axi_arready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .rst_cascade   (rst_cascade)
);

// ==== tb/rst_dist_input.txt ====
// Hex words, one transaction per line: op addr data strb resp expected_data
// op 1 write, 2 read, 3 wait for rst_cascade == expected_data, data = edges after write, 0 ends
2 0 00000000 0 0 00000001
2 4 00000000 0 0 0000000f
1 0 00000000 f 0 00000000
3 0 00000002 0 0 00000007
3 0 00000003 0 0 00000003
3 0 00000004 0 0 00000001
3 0 00000005 0 0 00000000
2 4 00000000 0 0 00000000
2 0 00000000 0 0 00000000
1 0 00000001 f 0 00000000
3 0 00000002 0 0 0000000f
2 4 00000000 0 0 0000000f
2 0 00000000 0 0 00000001
1 0 00000000 e 0 00000000
2 0 00000000 0 0 00000001
2 4 00000000 0 0 0000000f
2 8 00000000 0 2 00000000
2 c 00000000 0 2 00000000
1 4 00000000 f 2 00000000
1 8 00000000 f 2 00000000
2 0 00000000 0 0 00000001
2 4 00000000 0 0 0000000f
0 0 00000000 0 0 00000000

// ==== tb/tb_cascaded_reset_dist.sv ====
// Testbench for the reset distributor, replays AXI transactions listed in the input data file
`timescale 1ns/1ps

module tb_cascaded_reset_dist;
    import rst_dist_pkg::*;

    localparam int MAX_WORDS = 6 * 64;
    localparam int TIMEOUT   = 50;

    logic                s_axi_aclk;
    logic                s_axi_aresetn;
    logic [31:0]         s_axi_awaddr;
    logic [2:0]          s_axi_awprot;
    logic                s_axi_awvalid;
    logic                s_axi_awready;
    logic [31:0]         s_axi_wdata;
    logic [3:0]          s_axi_wstrb;
    logic                s_axi_wvalid;
    logic                s_axi_wready;
    logic [1:0]          s_axi_bresp;
    logic                s_axi_bvalid;
    logic                s_axi_bready;
    logic [31:0]         s_axi_araddr;
    logic [2:0]          s_axi_arprot;
    logic                s_axi_arvalid;
    logic                s_axi_arready;
    logic [31:0]         s_axi_rdata;
    logic [1:0]          s_axi_rresp;
    logic                s_axi_rvalid;
    logic                s_axi_rready;
    logic [N_STAGES-1:0] rst_cascade;

    // Six words per transaction: op, addr, data, strb, resp, expected
    logic [31:0]         stim [0:MAX_WORDS-1];
    int                  errors = 0;
    int                  timeouts = 0;
    int                  checks = 0;
    int                  edge_cnt = 0;
    int                  commit_edge = 0;
    // Edge number at which each rst_cascade value last appeared
    int                  appear_edge [0:2**N_STAGES-1] = '{default: -1};
    logic [N_STAGES-1:0] last_seen = '1;

    cascaded_reset_dist UUT (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awprot  (s_axi_awprot),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arprot  (s_axi_arprot),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .rst_cascade   (rst_cascade)
    );

    initial begin
        s_axi_aclk = 1'b0;
        forever #2 s_axi_aclk = ~s_axi_aclk;
    end

    // Values sampled here were set at the previous edge
    always @(posedge s_axi_aclk) begin
        edge_cnt <= edge_cnt + 1;
        if (s_axi_aresetn && rst_cascade != last_seen) begin
            appear_edge[rst_cascade] <= edge_cnt;
            last_seen <= rst_cascade;
        end
    end

    task automatic axi_write(input logic [ADDR_BITS-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [1:0] exp_resp);
        int   waited;
        int   stall;
        logic ok;
        s_axi_awaddr  <= {{(32-ADDR_BITS){1'b0}}, addr};
        s_axi_wdata   <= data;
        s_axi_wstrb   <= strb;
        s_axi_awvalid <= 1'b1;
        s_axi_wvalid  <= 1'b1;
        waited = 0;
        @(posedge s_axi_aclk);
        // Both channels are accepted in the same cycle
        while (!(s_axi_awready && s_axi_wready) && waited < TIMEOUT) begin
            @(posedge s_axi_aclk);
            waited++;
        end
        ok = s_axi_awready && s_axi_wready;
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        if (!ok) begin
            $display("Timeout at %0t: write to 0x%h was never accepted", $time, addr);
            timeouts++;
            return;
        end
        commit_edge = edge_cnt + 1;
        // Random bready back-pressure
        stall = $urandom % 4;
        repeat (stall) @(posedge s_axi_aclk);
        s_axi_bready <= 1'b1;
        waited = 0;
        @(posedge s_axi_aclk);
        while (!s_axi_bvalid && waited < TIMEOUT) begin
            @(posedge s_axi_aclk);
            waited++;
        end
        ok = s_axi_bvalid;
        s_axi_bready <= 1'b0;
        if (!ok) begin
            $display("Timeout at %0t: no write response for 0x%h", $time, addr);
            timeouts++;
            return;
        end
        checks++;
        assert (s_axi_bresp == exp_resp) else begin
            $display("Mismatch at %0t: write to 0x%h gave response %b, expected %b",
                     $time, addr, s_axi_bresp, exp_resp);
            errors++;
        end
    endtask

    task automatic axi_read(input logic [ADDR_BITS-1:0] addr, input logic [1:0] exp_resp,
                            input logic [31:0] exp_data);
        int   waited;
        int   stall;
        logic ok;
        s_axi_araddr  <= {{(32-ADDR_BITS){1'b0}}, addr};
        s_axi_arvalid <= 1'b1;
        waited = 0;
        @(posedge s_axi_aclk);
        while (!s_axi_arready && waited < TIMEOUT) begin
            @(posedge s_axi_aclk);
            waited++;
        end
        ok = s_axi_arready;
        s_axi_arvalid <= 1'b0;
        if (!ok) begin
            $display("Timeout at %0t: read of 0x%h was never accepted", $time, addr);
            timeouts++;
            return;
        end
        stall = $urandom % 4;
        repeat (stall) @(posedge s_axi_aclk);
        s_axi_rready <= 1'b1;
        waited = 0;
        @(posedge s_axi_aclk);
        while (!s_axi_rvalid && waited < TIMEOUT) begin
            @(posedge s_axi_aclk);
            waited++;
        end
        ok = s_axi_rvalid;
        s_axi_rready <= 1'b0;
        if (!ok) begin
            $display("Timeout at %0t: no read data for 0x%h", $time, addr);
            timeouts++;
            return;
        end
        checks++;
        assert (s_axi_rresp == exp_resp && s_axi_rdata == exp_data) else begin
            $display("Mismatch at %0t: read of 0x%h gave 0x%h resp %b, expected 0x%h resp %b",
                     $time, addr, s_axi_rdata, s_axi_rresp, exp_data, exp_resp);
            errors++;
        end
    endtask

    // Waits for a cascade value that appeared after the last write, then checks its delay
    task automatic wait_cascade(input logic [N_STAGES-1:0] target, input int delay);
        int waited;
        int seen_delay;
        waited = 0;
        while (appear_edge[target] < commit_edge && waited < TIMEOUT) begin
            @(posedge s_axi_aclk);
            waited++;
        end
        if (appear_edge[target] < commit_edge) begin
            $display("Timeout at %0t: rst_cascade never reached 0x%h", $time, target);
            timeouts++;
        end else begin
            seen_delay = appear_edge[target] - commit_edge;
            checks++;
            assert (seen_delay == delay) else begin
                $display("Mismatch at %0t: rst_cascade 0x%h came %0d edges after write, expected %0d",
                         $time, target, seen_delay, delay);
                errors++;
            end
        end
    endtask

    initial begin
        int          idx;
        logic [31:0] op;
        void'($urandom(32'hc3b8));
        s_axi_aresetn = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awprot  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arprot  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        for (idx = 0; idx < MAX_WORDS; idx++) begin
            stim[idx] = '0;
        end
        $readmemh("tb/rst_dist_input.txt", stim);

        repeat (3) @(posedge s_axi_aclk);
        s_axi_aresetn <= 1'b1;
        @(posedge s_axi_aclk);
        checks++;
        assert (rst_cascade == '1 && !s_axi_bvalid && !s_axi_rvalid && !s_axi_awready)
        else begin
            $display("Mismatch at %0t: outputs not at reset values, rst_cascade 0x%h",
                     $time, rst_cascade);
            errors++;
        end

        idx = 0;
        while (idx + 5 < MAX_WORDS && stim[idx] != 32'h0) begin
            op = stim[idx];
            case (op)
                32'h1: axi_write(stim[idx+1][ADDR_BITS-1:0], stim[idx+2],
                                 stim[idx+3][3:0], stim[idx+4][1:0]);
                32'h2: axi_read(stim[idx+1][ADDR_BITS-1:0], stim[idx+4][1:0], stim[idx+5]);
                32'h3: wait_cascade(stim[idx+5][N_STAGES-1:0], int'(stim[idx+2]));
                default: begin
                    $display("Unknown operation code 0x%h in transaction %0d", op, idx / 6 + 1);
                    errors++;
                end
            endcase
            idx += 6;
        end

        repeat (4) @(posedge s_axi_aclk);
        $display("Done: %0d checks, %0d mismatches, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
